//--- src.f
+incdir+verification
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/bus_arbiter.sv
rtl/banked_mem.sv
rtl/mem_system_top.sv
verification/mem_system_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run into sim.log, pass only on the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module mem_system_tb -f src.f -o mem_system_sim \
   && ./obj_dir/mem_system_sim > sim.log 2>&1
grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

//////////////////////////////
// Operation codes
//////////////////////////////
localparam logic [1:0] OP_READ  = 2'd0;
localparam logic [1:0] OP_WRITE = 2'd1;
// rd and wr raised together
localparam logic [1:0] OP_BAD   = 2'd2;
// Read with stray rd pulses while the port stalls
localparam logic [1:0] OP_NOISY = 2'd3;

typedef struct packed {
   logic        port;       // 0 for port a, 1 for port b
   logic [1:0]  op;
   logic        join_next;  // same start cycle as the next row
   logic [15:0] addr;
   logic [15:0] seed;       // 0 takes the next LCG word on a write
   logic        exp_hit;
   logic        exp_err;
} vec_t;

localparam int NUM_ROWS = 31;

// Columns: port, op, join_next, addr, seed, exp_hit, exp_err
localparam vec_t VECTORS [NUM_ROWS] = '{
   '{1'b0, OP_READ,  1'b0, 16'h0810, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h0812, 16'h0000, 1'b1, 1'b0},
   '{1'b0, OP_WRITE, 1'b0, 16'h0814, 16'h0000, 1'b1, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h0814, 16'h0000, 1'b1, 1'b0},
   '{1'b0, OP_WRITE, 1'b0, 16'h0816, 16'hbeef, 1'b1, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h1010, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h0814, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h0816, 16'h0000, 1'b1, 1'b0},
   '{1'b0, OP_BAD,   1'b0, 16'h0820, 16'h1234, 1'b0, 1'b1},
   '{1'b0, OP_READ,  1'b0, 16'h0821, 16'h0000, 1'b0, 1'b1},
   '{1'b0, OP_READ,  1'b0, 16'h0820, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_WRITE, 1'b0, 16'h0823, 16'h5555, 1'b0, 1'b1},
   '{1'b0, OP_READ,  1'b0, 16'h0822, 16'h0000, 1'b1, 1'b0},
   '{1'b1, OP_WRITE, 1'b0, 16'h8810, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_READ,  1'b0, 16'h8810, 16'h0000, 1'b1, 1'b0},
   '{1'b0, OP_WRITE, 1'b0, 16'h2030, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_WRITE, 1'b0, 16'ha030, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b1, 16'h3030, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_READ,  1'b0, 16'hb030, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b1, 16'h2030, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_READ,  1'b0, 16'ha030, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_NOISY, 1'b0, 16'h1010, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_READ,  1'b0, 16'h0814, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_NOISY, 1'b0, 16'h9012, 16'h0000, 1'b0, 1'b0},
   '{1'b1, OP_READ,  1'b0, 16'h8810, 16'h0000, 1'b0, 1'b0},
   '{1'b0, OP_WRITE, 1'b1, 16'h0810, 16'h0a0a, 1'b1, 1'b0},
   '{1'b1, OP_WRITE, 1'b0, 16'h8810, 16'h0b0b, 1'b1, 1'b0},
   '{1'b0, OP_READ,  1'b1, 16'h0810, 16'h0000, 1'b1, 1'b0},
   '{1'b1, OP_READ,  1'b0, 16'h8810, 16'h0000, 1'b1, 1'b0},
   '{1'b1, OP_BAD,   1'b0, 16'h9000, 16'h0000, 1'b0, 1'b1},
   '{1'b1, OP_READ,  1'b0, 16'h9001, 16'h0000, 1'b0, 1'b1}
};

`endif

//--- verification/mem_system_tb.sv
`timescale 1ns/1ps

module mem_system_tb;
   import cache_pkg::*;

   `include "tb_vectors.svh"

   localparam int CLK_NS      = 20;
   // Generous budget per table row
   localparam int WATCHDOG_NS = NUM_ROWS * 200 * CLK_NS;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] addr_a;
   logic [DATA_W-1:0] wdata_a;
   logic              rd_a;
   logic              wr_a;
   logic [DATA_W-1:0] rdata_a;
   logic              done_a;
   logic              stall_a;
   logic              cache_hit_a;
   logic              err_a;
   logic [ADDR_W-1:0] addr_b;
   logic [DATA_W-1:0] wdata_b;
   logic              rd_b;
   logic              wr_b;
   logic [DATA_W-1:0] rdata_b;
   logic              done_b;
   logic              stall_b;
   logic              cache_hit_b;
   logic              err_b;

   int                errors;
   logic [31:0]       lcg_state;

   //////////////////////////////
   // Reference model
   //////////////////////////////
   // Word as the processor sees it
   logic [DATA_W-1:0] shadow [MEM_WORDS];
   // Line owner per port, predicts the hit
   logic [TAG_W-1:0]  model_tag [NUM_MASTERS][LINES];
   logic              model_valid [NUM_MASTERS][LINES];

   mem_system_top i_dut (
      .clk(clk), .rst(rst),
      .addr_a(addr_a), .wdata_a(wdata_a), .rd_a(rd_a), .wr_a(wr_a),
      .rdata_a(rdata_a), .done_a(done_a), .stall_a(stall_a),
      .cache_hit_a(cache_hit_a), .err_a(err_a),
      .addr_b(addr_b), .wdata_b(wdata_b), .rd_b(rd_b), .wr_b(wr_b),
      .rdata_b(rdata_b), .done_b(done_b), .stall_b(stall_b),
      .cache_hit_b(cache_hit_b), .err_b(err_b)
   );

   always #(CLK_NS / 2) clk = ~clk;

   //////////////////////////////
   // Helpers
   //////////////////////////////
   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Explicit seed wins, else next LCG word
   function automatic logic [DATA_W-1:0] next_wdata(input vec_t v);
      if (v.op != OP_WRITE || v.seed != 16'h0000) return v.seed;
      lcg_state = lcg_step(lcg_state);
      return lcg_state[31:16];
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected) begin
         errors++;
         $display("mismatch %s: got %0h, expected %0h at %0t", name, got, expected, $time);
      end
   endtask

   task automatic drive_port(input int port, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d, input logic r, input logic w);
      if (port == 0) begin
         addr_a  = a;
         wdata_a = d;
         rd_a    = r;
         wr_a    = w;
      end else begin
         addr_b  = a;
         wdata_b = d;
         rd_b    = r;
         wr_b    = w;
      end
   endtask

   function automatic logic port_stall(input int port);
      return (port == 0) ? stall_a : stall_b;
   endfunction

   function automatic logic port_done(input int port);
      return (port == 0) ? done_a : done_b;
   endfunction

   task automatic sample_result(input int port, output logic hit, output logic err,
                                output logic [DATA_W-1:0] rdata);
      hit   = (port == 0) ? cache_hit_a : cache_hit_b;
      err   = (port == 0) ? err_a : err_b;
      rdata = (port == 0) ? rdata_a : rdata_b;
   endtask

   task automatic wait_ports_idle();
      while (stall_a !== 1'b0 || stall_b !== 1'b0) begin
         @(negedge clk);
      end
   endtask

   //////////////////////////////
   // One table row on one port
   //////////////////////////////
   task automatic run_access(input int row, input logic [DATA_W-1:0] data);
      vec_t               v;
      int                 port;
      string              sfx;
      logic               rd_v;
      logic               wr_v;
      logic               bad;
      logic               hit_exp;
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] idx;
      int                 cycles;
      logic               finished;
      logic               got_hit;
      logic               got_err;
      logic [DATA_W-1:0]  got_rdata;
      v    = VECTORS[row];
      port = int'(v.port);
      sfx  = (port == 0) ? "_a" : "_b";
      rd_v = (v.op != OP_WRITE);
      wr_v = (v.op == OP_WRITE) || (v.op == OP_BAD);
      // Rejected on both strobes or an odd byte address
      bad  = (rd_v && wr_v) || v.addr[0];
      tag  = v.addr[15:11];
      idx  = v.addr[10:3];
      hit_exp = !bad && model_valid[port][idx] && (model_tag[port][idx] == tag);
      if (v.exp_hit !== hit_exp || v.exp_err !== bad) begin
         errors++;
         $display("Row %0d: table expectation disagrees with the reference model", row);
      end
      while (port_stall(port) !== 1'b0) begin
         @(negedge clk);
      end
      drive_port(port, v.addr, data, rd_v, wr_v);
      @(negedge clk);
      cycles   = 0;
      finished = 1'b0;
      // Strobes drop first so the idle cycle after done takes nothing
      while (!finished) begin
         drive_port(port, v.addr, data, 1'b0, 1'b0);
         if (port_done(port) === 1'b1) begin
            finished = 1'b1;
         end else begin
            // Stray reads while stalled
            if (v.op == OP_NOISY && cycles % 2 == 1) begin
               drive_port(port, v.addr ^ 16'h0808, data, 1'b1, 1'b0);
            end
            @(negedge clk);
            cycles++;
         end
      end
      sample_result(port, got_hit, got_err, got_rdata);
      check_value({"err", sfx}, 32'(got_err), 32'(bad));
      check_value({"cache_hit", sfx}, 32'(got_hit), 32'(hit_exp));
      if (!bad) begin
         if (wr_v) begin
            shadow[v.addr[15:1]] = data;
         end else begin
            check_value({"rdata", sfx}, 32'(got_rdata), 32'(shadow[v.addr[15:1]]));
         end
         // Any accepted access leaves the line resident
         model_valid[port][idx] = 1'b1;
         model_tag[port][idx]   = tag;
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      int                row;
      logic [DATA_W-1:0] data_first;
      logic [DATA_W-1:0] data_second;
      clk       = 1'b0;
      rst       = 1'b1;
      errors    = 0;
      lcg_state = 32'h4093;
      drive_port(0, '0, '0, 1'b0, 1'b0);
      drive_port(1, '0, '0, 1'b0, 1'b0);
      // Memory starts cleared, caches start empty
      for (int w = 0; w < MEM_WORDS; w++) begin
         shadow[w] = '0;
      end
      for (int p = 0; p < NUM_MASTERS; p++) begin
         for (int l = 0; l < LINES; l++) begin
            model_tag[p][l]   = '0;
            model_valid[p][l] = 1'b0;
         end
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      // Valid sweep holds both ports in stall
      wait_ports_idle();
      row = 0;
      while (row < NUM_ROWS) begin
         wait_ports_idle();
         if (VECTORS[row].join_next && row + 1 < NUM_ROWS) begin
            data_first  = next_wdata(VECTORS[row]);
            data_second = next_wdata(VECTORS[row + 1]);
            // Both ports start on the same edge
            fork
               run_access(row, data_first);
               run_access(row + 1, data_second);
            join
            row += 2;
         end else begin
            data_first = next_wdata(VECTORS[row]);
            run_access(row, data_first);
            row++;
         end
      end
      $display("Run complete: %0d rows, %0d errors", NUM_ROWS, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Run limit
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not complete within %0d ns, %0d errors counted",
               WATCHDOG_NS, errors);
      $display("Finished with errors");
      $finish;
   end

endmodule

//--- rtl/mem_system_top.sv
`timescale 1ns/1ps

module mem_system_top (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [cache_pkg::ADDR_W-1:0] addr_a,
   input  logic [cache_pkg::DATA_W-1:0] wdata_a,
   input  logic                         rd_a,
   input  logic                         wr_a,
   output logic [cache_pkg::DATA_W-1:0] rdata_a,
   output logic                         done_a,
   output logic                         stall_a,
   output logic                         cache_hit_a,
   output logic                         err_a,
   input  logic [cache_pkg::ADDR_W-1:0] addr_b,
   input  logic [cache_pkg::DATA_W-1:0] wdata_b,
   input  logic                         rd_b,
   input  logic                         wr_b,
   output logic [cache_pkg::DATA_W-1:0] rdata_b,
   output logic                         done_b,
   output logic                         stall_b,
   output logic                         cache_hit_b,
   output logic                         err_b
);
   import cache_pkg::*;

   //////////////////////////////
   // Controller to array, index 0 is port a
   //////////////////////////////
   logic [NUM_MASTERS-1:0]               arr_en;
   logic [NUM_MASTERS-1:0]               arr_we;
   logic [NUM_MASTERS-1:0]               arr_set_valid;
   logic [NUM_MASTERS-1:0]               arr_set_dirty;
   logic [NUM_MASTERS-1:0][INDEX_W-1:0]  arr_index;
   logic [NUM_MASTERS-1:0][OFFSET_W-1:0] arr_offset;
   logic [NUM_MASTERS-1:0][TAG_W-1:0]    arr_tag;
   logic [NUM_MASTERS-1:0][DATA_W-1:0]   arr_wdata;
   logic [NUM_MASTERS-1:0][DATA_W-1:0]   arr_rdata;
   logic [NUM_MASTERS-1:0][TAG_W-1:0]    arr_tag_out;
   logic [NUM_MASTERS-1:0]               arr_valid;
   logic [NUM_MASTERS-1:0]               arr_dirty;
   logic [NUM_MASTERS-1:0]               arr_busy;

   // Wishbone masters and the shared slave
   logic [NUM_MASTERS-1:0]               m_cyc;
   logic [NUM_MASTERS-1:0]               m_stb;
   logic [NUM_MASTERS-1:0]               m_we;
   logic [NUM_MASTERS-1:0][ADDR_W-1:0]   m_adr;
   logic [NUM_MASTERS-1:0][DATA_W-1:0]   m_dat_w;
   logic [NUM_MASTERS-1:0]               m_ack;
   logic [DATA_W-1:0]                    m_dat_r;
   logic                                 s_cyc;
   logic                                 s_stb;
   logic                                 s_we;
   logic [ADDR_W-1:0]                    s_adr;
   logic [DATA_W-1:0]                    s_dat_w;
   logic [DATA_W-1:0]                    s_dat_r;
   logic                                 s_ack;

   //////////////////////////////
   // Port a
   //////////////////////////////
   cache_ctrl u_ctrl_a (
      .clk(clk), .rst(rst), .addr(addr_a), .wdata(wdata_a), .rd(rd_a), .wr(wr_a),
      .rdata(rdata_a), .done(done_a), .stall(stall_a), .cache_hit(cache_hit_a),
      .err(err_a), .arr_en(arr_en[0]), .arr_we(arr_we[0]),
      .arr_set_valid(arr_set_valid[0]), .arr_set_dirty(arr_set_dirty[0]),
      .arr_index(arr_index[0]), .arr_offset(arr_offset[0]), .arr_tag(arr_tag[0]),
      .arr_wdata(arr_wdata[0]), .arr_rdata(arr_rdata[0]), .arr_tag_out(arr_tag_out[0]),
      .arr_valid(arr_valid[0]), .arr_dirty(arr_dirty[0]), .arr_busy(arr_busy[0]),
      .cyc(m_cyc[0]), .stb(m_stb[0]), .we(m_we[0]), .adr(m_adr[0]),
      .dat_w(m_dat_w[0]), .dat_r(m_dat_r), .ack(m_ack[0])
   );

   cache_array u_array_a (
      .clk(clk), .rst(rst), .en(arr_en[0]), .we(arr_we[0]),
      .set_valid(arr_set_valid[0]), .set_dirty(arr_set_dirty[0]),
      .index(arr_index[0]), .offset(arr_offset[0]), .tag_in(arr_tag[0]),
      .wdata(arr_wdata[0]), .rdata(arr_rdata[0]), .tag_out(arr_tag_out[0]),
      .valid(arr_valid[0]), .dirty(arr_dirty[0]), .busy(arr_busy[0])
   );

   //////////////////////////////
   // Port b
   //////////////////////////////
   cache_ctrl u_ctrl_b (
      .clk(clk), .rst(rst), .addr(addr_b), .wdata(wdata_b), .rd(rd_b), .wr(wr_b),
      .rdata(rdata_b), .done(done_b), .stall(stall_b), .cache_hit(cache_hit_b),
      .err(err_b), .arr_en(arr_en[1]), .arr_we(arr_we[1]),
      .arr_set_valid(arr_set_valid[1]), .arr_set_dirty(arr_set_dirty[1]),
      .arr_index(arr_index[1]), .arr_offset(arr_offset[1]), .arr_tag(arr_tag[1]),
      .arr_wdata(arr_wdata[1]), .arr_rdata(arr_rdata[1]), .arr_tag_out(arr_tag_out[1]),
      .arr_valid(arr_valid[1]), .arr_dirty(arr_dirty[1]), .arr_busy(arr_busy[1]),
      .cyc(m_cyc[1]), .stb(m_stb[1]), .we(m_we[1]), .adr(m_adr[1]),
      .dat_w(m_dat_w[1]), .dat_r(m_dat_r), .ack(m_ack[1])
   );

   cache_array u_array_b (
      .clk(clk), .rst(rst), .en(arr_en[1]), .we(arr_we[1]),
      .set_valid(arr_set_valid[1]), .set_dirty(arr_set_dirty[1]),
      .index(arr_index[1]), .offset(arr_offset[1]), .tag_in(arr_tag[1]),
      .wdata(arr_wdata[1]), .rdata(arr_rdata[1]), .tag_out(arr_tag_out[1]),
      .valid(arr_valid[1]), .dirty(arr_dirty[1]), .busy(arr_busy[1])
   );

   // Shared bus into the banked memory
   bus_arbiter u_arbiter (
      .clk(clk), .rst(rst), .m_cyc(m_cyc), .m_stb(m_stb), .m_we(m_we),
      .m_adr(m_adr), .m_dat_w(m_dat_w), .m_ack(m_ack), .m_dat_r(m_dat_r),
      .s_cyc(s_cyc), .s_stb(s_stb), .s_we(s_we), .s_adr(s_adr),
      .s_dat_w(s_dat_w), .s_dat_r(s_dat_r), .s_ack(s_ack)
   );

   banked_mem u_mem (
      .clk(clk), .rst(rst), .cyc(s_cyc), .stb(s_stb), .we(s_we),
      .adr(s_adr), .dat_w(s_dat_w), .dat_r(s_dat_r), .ack(s_ack)
   );

endmodule

//--- rtl/banked_mem.sv
`timescale 1ns/1ps

module banked_mem (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         cyc,
   input  logic                         stb,
   input  logic                         we,
   input  logic [cache_pkg::ADDR_W-1:0] adr,
   input  logic [cache_pkg::DATA_W-1:0] dat_w,
   output logic [cache_pkg::DATA_W-1:0] dat_r,
   output logic                         ack
);
   import cache_pkg::*;

   // Four banks, word offset picks the bank
   logic [DATA_W-1:0] bank [WORDS_PER_LINE][BANK_WORDS];

   logic [WAIT_W-1:0]   wait_q;
   logic [OFFSET_W-1:0] sel;
   logic [BANK_W-1:0]   row;
   logic                serve;

   assign sel   = adr[1 +: OFFSET_W];
   assign row   = adr[ADDR_W-1 -: BANK_W];
   // Last wait cycle of a live strobe
   assign serve = cyc && stb && !ack && (wait_q == WAIT_W'(MEM_WAIT - 1));

   // Memory powers up cleared
   initial begin
      for (int b = 0; b < WORDS_PER_LINE; b++) begin
         for (int w = 0; w < BANK_WORDS; w++) begin
            bank[b][w] = '0;
         end
      end
   end

   // Wait count restarts with each new stb
   always_ff @(posedge clk) begin
      if (rst) begin
         ack    <= 1'b0;
         wait_q <= '0;
      end else begin
         ack <= serve;
         if (cyc && stb && !ack && !serve)
            wait_q <= wait_q + 1'b1;
         else
            wait_q <= '0;
      end
   end

   // Access lands on the edge that raises ack
   always_ff @(posedge clk) begin
      if (serve) begin
         if (we)
            bank[sel][row] <= dat_w;
         else
            dat_r <= bank[sel][row];
      end
   end

   // Master keeps stb up until its ack
   a_ack_in_strobe: assert property (
      @(posedge clk) disable iff (rst) ack |-> (cyc && stb)
   );

endmodule

//--- rtl/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                                                      clk,
   input  logic                                                      rst,
   input  logic [cache_pkg::NUM_MASTERS-1:0]                         m_cyc,
   input  logic [cache_pkg::NUM_MASTERS-1:0]                         m_stb,
   input  logic [cache_pkg::NUM_MASTERS-1:0]                         m_we,
   input  logic [cache_pkg::NUM_MASTERS-1:0][cache_pkg::ADDR_W-1:0]  m_adr,
   input  logic [cache_pkg::NUM_MASTERS-1:0][cache_pkg::DATA_W-1:0]  m_dat_w,
   output logic [cache_pkg::NUM_MASTERS-1:0]                         m_ack,
   output logic [cache_pkg::DATA_W-1:0]                              m_dat_r,
   output logic                                                      s_cyc,
   output logic                                                      s_stb,
   output logic                                                      s_we,
   output logic [cache_pkg::ADDR_W-1:0]                              s_adr,
   output logic [cache_pkg::DATA_W-1:0]                              s_dat_w,
   input  logic [cache_pkg::DATA_W-1:0]                              s_dat_r,
   input  logic                                                      s_ack
);
   import cache_pkg::*;

   logic [NUM_MASTERS-1:0] grant_q;
   logic [MASTER_W-1:0]    last_q;
   logic [MASTER_W-1:0]    owner;
   logic [MASTER_W-1:0]    pick;
   logic                   pick_ok;

   // Index of the granted master
   always_comb begin
      owner = '0;
      for (int i = 0; i < NUM_MASTERS; i++) begin
         if (grant_q[i]) owner = MASTER_W'(i);
      end
   end

   // First requester after the last winner, nearest one wins
   always_comb begin
      int idx;
      pick    = last_q;
      pick_ok = 1'b0;
      for (int i = NUM_MASTERS; i >= 1; i--) begin
         idx = (int'(last_q) + i) % NUM_MASTERS;
         if (m_cyc[idx]) begin
            pick    = MASTER_W'(idx);
            pick_ok = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         grant_q <= '0;
         // Master 0 goes first
         last_q  <= MASTER_W'(NUM_MASTERS - 1);
      end else if (grant_q == '0) begin
         if (pick_ok) grant_q <= NUM_MASTERS'(1) << pick;
      end else if (!m_cyc[owner]) begin
         // Line transfer over, priority moves on
         grant_q <= '0;
         last_q  <= owner;
      end
   end

   // Owner drives the slave, everyone else sees no ack
   assign s_cyc   = (grant_q != '0) && m_cyc[owner];
   assign s_stb   = s_cyc && m_stb[owner];
   assign s_we    = m_we[owner];
   assign s_adr   = m_adr[owner];
   assign s_dat_w = m_dat_w[owner];
   assign m_ack   = grant_q & {NUM_MASTERS{s_ack}};
   assign m_dat_r = s_dat_r;

   a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant_q));

   a_grant_held: assert property (
      @(posedge clk) disable iff (rst) (grant_q != '0 && m_cyc[owner]) |=> $stable(grant_q)
   );

endmodule

//--- rtl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                           clk,
   input  logic                           rst,
   input  logic [cache_pkg::ADDR_W-1:0]   addr,
   input  logic [cache_pkg::DATA_W-1:0]   wdata,
   input  logic                           rd,
   input  logic                           wr,
   output logic [cache_pkg::DATA_W-1:0]   rdata,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err,
   output logic                           arr_en,
   output logic                           arr_we,
   output logic                           arr_set_valid,
   output logic                           arr_set_dirty,
   output logic [cache_pkg::INDEX_W-1:0]  arr_index,
   output logic [cache_pkg::OFFSET_W-1:0] arr_offset,
   output logic [cache_pkg::TAG_W-1:0]    arr_tag,
   output logic [cache_pkg::DATA_W-1:0]   arr_wdata,
   input  logic [cache_pkg::DATA_W-1:0]   arr_rdata,
   input  logic [cache_pkg::TAG_W-1:0]    arr_tag_out,
   input  logic                           arr_valid,
   input  logic                           arr_dirty,
   input  logic                           arr_busy,
   output logic                           cyc,
   output logic                           stb,
   output logic                           we,
   output logic [cache_pkg::ADDR_W-1:0]   adr,
   output logic [cache_pkg::DATA_W-1:0]   dat_w,
   input  logic [cache_pkg::DATA_W-1:0]   dat_r,
   input  logic                           ack
);
   import cache_pkg::*;

   typedef enum logic [2:0] {
      S_IDLE,
      S_COMPARE,
      S_HIT,
      S_EVICT,
      S_FILL,
      S_FINISH
   } state_t;

   state_t state_q;
   state_t state_d;

   // Request held for the whole access
   logic [ADDR_W-1:0]   req_addr;
   logic [DATA_W-1:0]   req_wdata;
   logic                req_wr;
   logic                err_q;
   logic [DATA_W-1:0]   res_q;

   // Word counter and post-ack gap
   logic [OFFSET_W-1:0] cnt_q;
   logic                gap_q;

   logic [TAG_W-1:0]    req_tag;
   logic [INDEX_W-1:0]  req_index;
   logic [OFFSET_W-1:0] req_off;
   logic                take;
   logic                bad;
   logic                hit;
   logic                last_word;

   assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
   assign req_index = req_addr[OFFSET_W+1 +: INDEX_W];
   assign req_off   = req_addr[1 +: OFFSET_W];

   assign take      = (state_q == S_IDLE) && !arr_busy && (rd || wr);
   // Both strobes or an odd byte address
   assign bad       = (rd && wr) || addr[0];
   assign hit       = arr_valid && (arr_tag_out == req_tag);
   assign last_word = cnt_q == OFFSET_W'(WORDS_PER_LINE - 1);

   //////////////////////////////
   // State machine
   //////////////////////////////
   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE:    if (take) state_d = bad ? S_FINISH : S_COMPARE;
         S_COMPARE: begin
            if (hit)
               state_d = S_HIT;
            else if (arr_valid && arr_dirty)
               state_d = S_EVICT;
            else
               state_d = S_FILL;
         end
         S_EVICT:   if (ack && last_word) state_d = S_FILL;
         S_FILL:    if (ack && last_word) state_d = S_FINISH;
         default:   state_d = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= S_IDLE;
         err_q   <= 1'b0;
         cnt_q   <= '0;
         gap_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         // stb low for one cycle after every ack
         gap_q   <= ack;
         if (state_q == S_IDLE) begin
            cnt_q <= '0;
            if (take) err_q <= bad;
         end else if (ack) begin
            // Wraps to 0 between evict and fill
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (take) begin
         req_addr  <= addr;
         req_wdata <= wdata;
         req_wr    <= wr;
      end
      // Requested word as it comes back from memory
      if (state_q == S_FILL && ack && cnt_q == req_off) res_q <= dat_r;
   end

   //////////////////////////////
   // Array side
   //////////////////////////////
   always_comb begin
      arr_en        = 1'b0;
      arr_we        = 1'b0;
      arr_set_valid = 1'b0;
      arr_set_dirty = 1'b0;
      arr_index     = req_index;
      arr_offset    = req_off;
      arr_tag       = req_tag;
      arr_wdata     = req_wdata;
      case (state_q)
         S_IDLE: begin
            // Lookup straight from the port
            arr_index  = addr[OFFSET_W+1 +: INDEX_W];
            arr_offset = addr[1 +: OFFSET_W];
            arr_en     = take && !bad;
         end
         S_COMPARE: begin
            if (hit) begin
               // Write hit marks the line dirty
               arr_en        = req_wr;
               arr_we        = req_wr;
               arr_set_valid = 1'b1;
               arr_set_dirty = 1'b1;
            end else if (arr_valid && arr_dirty) begin
               // Preload victim word 0
               arr_en     = 1'b1;
               arr_offset = '0;
            end
         end
         S_EVICT: begin
            // Next victim word ready during the gap
            arr_en     = ack;
            arr_offset = cnt_q + 1'b1;
         end
         S_FILL: begin
            arr_en        = ack;
            arr_we        = ack;
            arr_offset    = cnt_q;
            // Pending store merges into its word
            arr_wdata     = (req_wr && cnt_q == req_off) ? req_wdata : dat_r;
            arr_set_valid = last_word;
            arr_set_dirty = last_word && req_wr;
         end
         default: ;
      endcase
   end

   //////////////////////////////
   // Bus and processor side
   //////////////////////////////

   // cyc drops for the gap between evict and fill
   assign cyc   = (state_q == S_EVICT || state_q == S_FILL) && !(gap_q && cnt_q == '0);
   assign stb   = cyc && !gap_q;
   assign we    = state_q == S_EVICT;
   // Victim goes to the old tag's address
   assign adr   = {(we ? arr_tag_out : req_tag), req_index, cnt_q, 1'b0};
   assign dat_w = arr_rdata;

   assign stall     = (state_q != S_IDLE) || arr_busy;
   assign done      = (state_q == S_HIT) || (state_q == S_FINISH);
   assign cache_hit = state_q == S_HIT;
   assign err       = (state_q == S_FINISH) && err_q;
   assign rdata     = (state_q == S_HIT) ? arr_rdata : res_q;

   // Strobe stays up until the word is acked
   a_stb_until_ack: assert property (@(posedge clk) disable iff (rst) (stb && !ack) |=> stb);

   a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

//--- rtl/cache_array.sv
`timescale 1ns/1ps

module cache_array (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           en,
   input  logic                           we,
   input  logic                           set_valid,
   input  logic                           set_dirty,
   input  logic [cache_pkg::INDEX_W-1:0]  index,
   input  logic [cache_pkg::OFFSET_W-1:0] offset,
   input  logic [cache_pkg::TAG_W-1:0]    tag_in,
   input  logic [cache_pkg::DATA_W-1:0]   wdata,
   output logic [cache_pkg::DATA_W-1:0]   rdata,
   output logic [cache_pkg::TAG_W-1:0]    tag_out,
   output logic                           valid,
   output logic                           dirty,
   output logic                           busy
);
   import cache_pkg::*;

   // Line storage
   logic [DATA_W-1:0] data_mem [LINES*WORDS_PER_LINE];
   logic [TAG_W-1:0]  tag_mem  [LINES];
   logic [LINES-1:0]  valid_bits;
   logic [LINES-1:0]  dirty_bits;

   // Clear sweep state
   logic [INDEX_W-1:0] clr_idx;
   logic               clearing;

   logic [INDEX_W+OFFSET_W-1:0] word_addr;

   // Line index above word offset
   assign word_addr = {index, offset};
   assign busy      = clearing;

   // Valid and dirty bits, swept clear one line per cycle after rst
   always_ff @(posedge clk) begin
      if (rst) begin
         clearing <= 1'b1;
         clr_idx  <= '0;
      end else if (clearing) begin
         valid_bits[clr_idx] <= 1'b0;
         dirty_bits[clr_idx] <= 1'b0;
         clr_idx             <= clr_idx + 1'b1;
         // Last line done
         if (clr_idx == INDEX_W'(LINES - 1)) begin
            clearing <= 1'b0;
         end
      end else if (en && we) begin
         // Controller picks the line state on every write
         valid_bits[index] <= set_valid;
         dirty_bits[index] <= set_dirty;
      end
   end

   // Data and tag, registered read of old contents
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            data_mem[word_addr] <= wdata;
            tag_mem[index]      <= tag_in;
         end
         rdata   <= data_mem[word_addr];
         tag_out <= tag_mem[index];
         valid   <= valid_bits[index];
         dirty   <= dirty_bits[index];
      end
   end

   // Controller holds off while the sweep runs
   a_no_access_while_clearing: assert property (
      @(posedge clk) disable iff (rst) clearing |-> !en
   );

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

   //////////////////////////////
   // Address fields
   //////////////////////////////

   // Byte address of 16-bit words
   localparam int ADDR_W   = 16;
   localparam int DATA_W   = 16;

   // Tag in bits 15 to 11
   localparam int TAG_W    = 5;

   // Index in bits 10 to 3
   localparam int INDEX_W  = 8;

   // Word within the line, bits 2 to 1
   localparam int OFFSET_W = 2;

   //////////////////////////////
   // Cache geometry
   //////////////////////////////
   localparam int LINES          = 256;
   localparam int WORDS_PER_LINE = 4;

   //////////////////////////////
   // Main memory and bus
   //////////////////////////////
   localparam int MEM_WORDS  = 32768;

   // One bank per word offset
   localparam int BANK_WORDS = MEM_WORDS / WORDS_PER_LINE;
   localparam int BANK_W     = $clog2(BANK_WORDS);

   // Cycles from stb rise to ack
   localparam int MEM_WAIT   = 2;
   localparam int WAIT_W     = $clog2(MEM_WAIT + 1);

   // Cache controllers behind the arbiter
   localparam int NUM_MASTERS = 2;
   localparam int MASTER_W    = $clog2(NUM_MASTERS);

endpackage
